// File: softmax_top.f
verilog/softmax_cfg_pkg.sv
verilog/softmax_num_pkg.sv
verilog/vector_buffer.sv
verilog/max_tree.sv
verilog/exp2_lanes.sv
verilog/adder_tree.sv
verilog/softmax_ctrl.sv
verilog/softmax_top.sv
verification/softmax_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the softmax testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module softmax_tb -f softmax_top.f \
  || { echo "verilator build failed"; exit 1; }

out=$(./obj_dir/Vsoftmax_tb)
echo "$out"

echo "$out" | grep -qx "Simulation finished: PASS" && exit 0 || exit 1

// File: verification/softmax_tb.sv
`timescale 1ns/1ps
`default_nettype none

module softmax_tb;

  import softmax_num_pkg::*;

  localparam int addr_w    = 4;
  localparam int num_cases = 4;
  localparam int mem_depth = 16;

  // window start, exclusive end, cycle of a stray second start (0 for none)
  int case_start   [num_cases] = '{0, 3, 0, 12};
  int case_end     [num_cases] = '{1, 9, 15, 15};
  int case_restart [num_cases] = '{0, 4, 20, 2};

  logic              clk;
  logic              reset;
  logic              start;
  logic [addr_w-1:0] start_addr;
  logic [addr_w-1:0] end_addr;
  vec_t              inp;
  logic [addr_w-1:0] addr;
  exp_vec_t          exp_out;
  logic              exp_valid;
  sum_t              sum;
  logic              busy;
  logic              done;

  vec_t     mem_model [mem_depth];
  exp_vec_t expect_q [$];
  sum_t     expect_sum;
  int       seed;
  int       cycle_count;
  int       cycle_limit;
  int       value_errors;
  int       timing_errors;

  softmax_top #(
    .addr_w(addr_w)
  ) i_dut (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .start_addr(start_addr),
    .end_addr  (end_addr),
    .inp       (inp),
    .addr      (addr),
    .exp_out   (exp_out),
    .exp_valid (exp_valid),
    .sum       (sum),
    .busy      (busy),
    .done      (done)
  );

  // external memory answers in the same cycle
  assign inp = mem_model[addr];

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // elements in -12..11
  task automatic fill_memory();
    int r;
    for (int a = 0; a < mem_depth; a++) begin
      for (int l = 0; l < 4; l++) begin
        r = $random(seed) % 24;
        if (r < 0) begin
          r = r + 24;
        end
        mem_model[a][l] = elem_t'(r - 12);
      end
    end
  endtask

  // 2^-(top-x) in Q1.15
  function automatic exp_t lane_exp(elem_t top, elem_t x);
    int d;
    d = int'(top) - int'(x);
    if (d >= 16) begin
      return '0;
    end else begin
      return exp_t'(32768 >> d);
    end
  endfunction

  task automatic build_expected(int c);
    elem_t    top;
    exp_vec_t ev;
    top = mem_model[case_start[c]][0];
    for (int a = case_start[c]; a < case_end[c]; a++) begin
      for (int l = 0; l < 4; l++) begin
        if (mem_model[a][l] > top) begin
          top = mem_model[a][l];
        end
      end
    end
    expect_q.delete();
    expect_sum = '0;
    for (int a = case_start[c]; a < case_end[c]; a++) begin
      for (int l = 0; l < 4; l++) begin
        ev[l] = lane_exp(top, mem_model[a][l]);
        expect_sum = expect_sum + sum_t'(ev[l]);
      end
      expect_q.push_back(ev);
    end
  endtask

  task automatic check_idle();
    if (busy !== 1'b0 || done !== 1'b0 || exp_valid !== 1'b0) begin
      timing_errors++;
      $display("ERROR at %0t: busy %b done %b exp_valid %b after reset, expected all low",
               $time, busy, done, exp_valid);
    end
    if (sum !== '0 || exp_out !== '0 || addr !== '0) begin
      value_errors++;
      $display("ERROR at %0t: sum %0d exp_out %h addr %0d after reset, expected zero",
               $time, sum, exp_out, addr);
    end
  endtask

  task automatic run_case(int c);
    int       n;
    int       j;
    int       pulses;
    int       want_addr;
    bit       seen_done;
    exp_vec_t want;
    n = case_end[c] - case_start[c];
    build_expected(c);
    start_addr = addr_w'(case_start[c]);
    end_addr   = addr_w'(case_end[c]);
    start      = 1'b1;
    @(negedge clk);
    start     = 1'b0;
    j         = 0;
    pulses    = 0;
    seen_done = 1'b0;
    // j counts rising edges since the one that took start
    while (!seen_done) begin
      // load pass walks the window, then addr parks at zero
      if (j < n) begin
        want_addr = case_start[c] + j;
      end else begin
        want_addr = 0;
      end
      if (addr !== addr_w'(want_addr)) begin
        value_errors++;
        $display("ERROR at %0t: case %0d addr %0d at edge %0d, expected %0d",
                 $time, c, addr, j, want_addr);
      end
      if (exp_valid) begin
        if (pulses >= n) begin
          timing_errors++;
          $display("ERROR at %0t: case %0d extra exp_valid pulse", $time, c);
        end else begin
          want = expect_q[pulses];
          if (exp_out !== want) begin
            value_errors++;
            $display("ERROR at %0t: case %0d vector %0d exp_out %h expected %h",
                     $time, c, pulses, exp_out, want);
          end
          if (j != n + 3 + pulses) begin
            timing_errors++;
            $display("ERROR at %0t: case %0d vector %0d valid at edge %0d, expected %0d",
                     $time, c, pulses, j, n + 3 + pulses);
          end
        end
        pulses++;
      end
      if (done) begin
        seen_done = 1'b1;
        if (j != 2 * n + 5) begin
          timing_errors++;
          $display("ERROR at %0t: case %0d done at edge %0d, expected %0d",
                   $time, c, j, 2 * n + 5);
        end
        if (busy !== 1'b0) begin
          timing_errors++;
          $display("ERROR at %0t: case %0d busy still high with done", $time, c);
        end
        if (sum !== expect_sum) begin
          value_errors++;
          $display("ERROR at %0t: case %0d sum %0d expected %0d", $time, c, sum, expect_sum);
        end
      end else if (busy !== 1'b1) begin
        timing_errors++;
        $display("ERROR at %0t: case %0d busy low at edge %0d before done", $time, c, j);
      end
      // stray start with a different window that must be ignored
      if (case_restart[c] != 0 && j == case_restart[c]) begin
        start_addr = addr_w'(1);
        end_addr   = addr_w'(2);
        start      = 1'b1;
      end else begin
        start = 1'b0;
      end
      @(negedge clk);
      j++;
    end
    if (done || exp_valid) begin
      timing_errors++;
      $display("ERROR at %0t: case %0d done %b exp_valid %b one cycle after done",
               $time, c, done, exp_valid);
    end
    if (pulses != n) begin
      timing_errors++;
      $display("ERROR at %0t: case %0d saw %0d exp_valid pulses, expected %0d",
               $time, c, pulses, n);
    end
  endtask

  initial begin
    seed          = 87;
    value_errors  = 0;
    timing_errors = 0;
    cycle_count   = 0;
    cycle_limit   = 50;
    for (int c = 0; c < num_cases; c++) begin
      cycle_limit = cycle_limit + 2 * (case_end[c] - case_start[c]) + 20;
    end
    reset      = 1'b1;
    start      = 1'b0;
    start_addr = '0;
    end_addr   = '0;
    fill_memory();
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_idle();
    for (int c = 0; c < num_cases; c++) begin
      run_case(c);
    end
    $display("errors: %0d value, %0d timing", value_errors, timing_errors);
    if (value_errors == 0 && timing_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/softmax_top.sv
`timescale 1ns/1ps
`default_nettype none

module softmax_top #(
  parameter int addr_w = softmax_cfg_pkg::addr_w_default
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      start,
  input  logic [addr_w-1:0]         start_addr,
  input  logic [addr_w-1:0]         end_addr,
  input  softmax_num_pkg::vec_t     inp,
  output logic [addr_w-1:0]         addr,
  output softmax_num_pkg::exp_vec_t exp_out,
  output logic                      exp_valid,
  output softmax_num_pkg::sum_t     sum,
  output logic                      busy,
  output logic                      done
);

  import softmax_num_pkg::*;

  logic [addr_w-1:0] wr_addr;
  logic [addr_w-1:0] rd_addr;
  logic              load_run;
  logic              max_clear;
  logic              rd_en;
  logic              lane_run;
  logic              sum_run;
  logic              acc_run;
  logic              acc_clear;
  vec_t              rd_data;
  elem_t             max_out;

  softmax_ctrl #(
    .addr_w(addr_w)
  ) u_ctrl (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .start_addr(start_addr),
    .end_addr  (end_addr),
    .addr      (addr),
    .wr_addr   (wr_addr),
    .rd_addr   (rd_addr),
    .load_run  (load_run),
    .max_clear (max_clear),
    .rd_en     (rd_en),
    .lane_run  (lane_run),
    .sum_run   (sum_run),
    .acc_run   (acc_run),
    .acc_clear (acc_clear),
    .exp_valid (exp_valid),
    .busy      (busy),
    .done      (done)
  );

  vector_buffer #(
    .addr_w(addr_w)
  ) u_buffer (
    .clk     (clk),
    .load_run(load_run),
    .wr_addr (wr_addr),
    .inp     (inp),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  // running max sees inp on the same edge the buffer writes it
  max_tree u_max (
    .clk      (clk),
    .reset    (reset),
    .max_clear(max_clear),
    .load_run (load_run),
    .inp      (inp),
    .max_out  (max_out)
  );

  exp2_lanes u_exp (
    .clk     (clk),
    .reset   (reset),
    .lane_run(lane_run),
    .rd_data (rd_data),
    .max_out (max_out),
    .exp_out (exp_out)
  );

  adder_tree u_sum (
    .clk      (clk),
    .reset    (reset),
    .sum_run  (sum_run),
    .acc_run  (acc_run),
    .acc_clear(acc_clear),
    .exp_out  (exp_out),
    .sum      (sum)
  );

endmodule

`default_nettype wire

// File: verilog/softmax_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module softmax_ctrl #(
  parameter int addr_w = softmax_cfg_pkg::addr_w_default
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  logic [addr_w-1:0] start_addr,
  input  logic [addr_w-1:0] end_addr,
  output logic [addr_w-1:0] addr,
  output logic [addr_w-1:0] wr_addr,
  output logic [addr_w-1:0] rd_addr,
  output logic              load_run,
  output logic              max_clear,
  output logic              rd_en,
  output logic              lane_run,
  output logic              sum_run,
  output logic              acc_run,
  output logic              acc_clear,
  output logic              exp_valid,
  output logic              busy,
  output logic              done
);

  logic [addr_w-1:0] first_q;
  logic [addr_w-1:0] end_q;
  logic [addr_w-1:0] last_addr;
  logic              launch;
  logic              read_arm;
  logic              acc_tail;
  logic              chain_end;

  // start while busy is dropped
  assign launch    = start && !busy;
  assign last_addr = end_q - 1'b1;
  assign chain_end = acc_tail && !acc_run;

  // max and accumulator restart on the launch edge
  assign max_clear = launch;
  assign acc_clear = launch;

  assign wr_addr   = addr;
  // stage one sums exactly while the exponentials are valid
  assign exp_valid = sum_run;

  always_ff @(posedge clk) begin
    if (launch) begin
      first_q <= start_addr;
      end_q   <= end_addr;
    end
  end

  // load pass, addr leads the sampling edge by one cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      addr     <= '0;
      load_run <= 1'b0;
      read_arm <= 1'b0;
    end else begin
      read_arm <= 1'b0;
      if (launch) begin
        addr     <= start_addr;
        load_run <= 1'b1;
      end else if (load_run) begin
        if (addr == last_addr) begin
          addr     <= '0;
          load_run <= 1'b0;
          read_arm <= 1'b1;
        end else begin
          addr <= addr + 1'b1;
        end
      end
    end
  end

  // read pass starts one cycle after the max is final
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_addr <= '0;
      rd_en   <= 1'b0;
    end else if (read_arm) begin
      rd_addr <= first_q;
      rd_en   <= 1'b1;
    end else if (rd_en) begin
      if (rd_addr == last_addr) begin
        rd_addr <= '0;
        rd_en   <= 1'b0;
      end else begin
        rd_addr <= rd_addr + 1'b1;
      end
    end
  end

  // strobe chain, one stage per pipeline register
  always_ff @(posedge clk) begin
    if (reset) begin
      lane_run <= 1'b0;
      sum_run  <= 1'b0;
      acc_run  <= 1'b0;
      acc_tail <= 1'b0;
      done     <= 1'b0;
      busy     <= 1'b0;
    end else begin
      lane_run <= rd_en;
      sum_run  <= lane_run;
      acc_run  <= sum_run;
      acc_tail <= acc_run;
      done     <= chain_end;
      if (launch) begin
        busy <= 1'b1;
      end else if (chain_end) begin
        busy <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/adder_tree.sv
`timescale 1ns/1ps
`default_nettype none

module adder_tree (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      sum_run,
  input  logic                      acc_run,
  input  logic                      acc_clear,
  input  softmax_num_pkg::exp_vec_t exp_out,
  output softmax_num_pkg::sum_t     sum
);

  import softmax_num_pkg::*;

  // pair sums carry one bit more than an exponential
  logic [$bits(exp_t):0] pair_lo;
  logic [$bits(exp_t):0] pair_hi;

  // stage one
  always_ff @(posedge clk) begin
    if (sum_run) begin
      pair_lo <= exp_out[0] + exp_out[1];
      pair_hi <= exp_out[2] + exp_out[3];
    end
  end

  // stage two folds both pairs into the running total
  always_ff @(posedge clk) begin
    if (reset || acc_clear) begin
      sum <= '0;
    end else if (acc_run) begin
      sum <= sum + pair_lo + pair_hi;
    end
  end

endmodule

`default_nettype wire

// File: verilog/exp2_lanes.sv
`timescale 1ns/1ps
`default_nettype none

module exp2_lanes (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      lane_run,
  input  softmax_num_pkg::vec_t     rd_data,
  input  softmax_num_pkg::elem_t    max_out,
  output softmax_num_pkg::exp_vec_t exp_out
);

  import softmax_cfg_pkg::*;
  import softmax_num_pkg::*;

  // one extra bit so max minus element cannot wrap
  typedef logic signed [$bits(elem_t):0] diff_t;

  diff_t    diff [num_lanes];
  exp_vec_t exp_next;

  always_comb begin
    for (int i = 0; i < num_lanes; i++) begin
      diff[i] = max_out - elem_t'(rd_data[i]);
      // 2^-diff as a right shift of one
      if (diff[i] >= exp_shift_limit) begin
        exp_next[i] = '0;
      end else begin
        exp_next[i] = exp_one >> diff[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      exp_out <= '0;
    end else if (lane_run) begin
      exp_out <= exp_next;
    end
  end

endmodule

`default_nettype wire

// File: verilog/max_tree.sv
`timescale 1ns/1ps
`default_nettype none

module max_tree (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   max_clear,
  input  logic                   load_run,
  input  softmax_num_pkg::vec_t  inp,
  output softmax_num_pkg::elem_t max_out
);

  import softmax_num_pkg::*;

  // most negative element
  localparam elem_t elem_min = {1'b1, {($bits(elem_t) - 1){1'b0}}};

  elem_t win_lo;
  elem_t win_hi;
  elem_t vec_max;

  function automatic elem_t larger(input elem_t a, input elem_t b);
    return (a > b) ? a : b;
  endfunction

  // pair the lanes, then the pair winners
  assign win_lo  = larger(inp[0], inp[1]);
  assign win_hi  = larger(inp[2], inp[3]);
  assign vec_max = larger(win_lo, win_hi);

  always_ff @(posedge clk) begin
    if (reset || max_clear) begin
      max_out <= elem_min;
    end else if (load_run) begin
      max_out <= larger(max_out, vec_max);
    end
  end

endmodule

`default_nettype wire

// File: verilog/vector_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module vector_buffer #(
  parameter int addr_w = softmax_cfg_pkg::addr_w_default
) (
  input  logic                  clk,
  input  logic                  load_run,
  input  logic [addr_w-1:0]     wr_addr,
  input  softmax_num_pkg::vec_t inp,
  input  logic                  rd_en,
  input  logic [addr_w-1:0]     rd_addr,
  output softmax_num_pkg::vec_t rd_data
);

  import softmax_num_pkg::*;

  vec_t mem [2**addr_w];

  always_ff @(posedge clk) begin
    if (load_run) begin
      mem[wr_addr] <= inp;
    end
  end

  // registered read, data follows rd_en by one cycle
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// File: verilog/softmax_num_pkg.sv
`default_nettype none

package softmax_num_pkg;

  typedef logic signed [15:0] elem_t;

  // lane 0 in the low bits
  typedef elem_t [softmax_cfg_pkg::num_lanes-1:0] vec_t;

  // unsigned Q1.15
  typedef logic [15:0] exp_t;
  typedef exp_t [softmax_cfg_pkg::num_lanes-1:0] exp_vec_t;

  typedef logic [23:0] sum_t;

  // 1.0 in Q1.15
  localparam exp_t exp_one = 16'h8000;

  // differences at or past this shift everything out
  localparam int exp_shift_limit = 16;

endpackage

`default_nettype wire

// File: verilog/softmax_cfg_pkg.sv
`default_nettype none

package softmax_cfg_pkg;

  // elements per vector
  // the compare and adder trees are built for exactly four
  localparam int num_lanes = 4;

  // gives a 16-vector buffer
  localparam int addr_w_default = 4;

endpackage

`default_nettype wire
